//--- bp_top.f
common/bp_pkg.sv
rtl/bp_mem_arbiter.sv
clint/bp_clint_regs.sv
clint/bp_clint.sv
rtl/bp_top.sv
verification/bp_top_assert.sv
verification/bp_top_tb.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bp_top_tb \
   -f bp_top.f -o bp_top_sim

out=$(./obj_dir/bp_top_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
   exit 0
fi
exit 1

//--- verification/bp_top_tb.sv
// testbench for bp_top with random core traffic, memory slave model and reference model
module bp_top_tb;

   localparam int timeout_cycles = 200;
   localparam int xfers_per_core = 40;

   logic                                                 clk_i;
   logic                                                 rst_n_i;
   logic [bp_pkg::num_core-1:0][bp_pkg::addr_width-1:0]  core_adr_i;
   bp_pkg::word_t [bp_pkg::num_core-1:0]                 core_dat_i;
   logic [bp_pkg::num_core-1:0]                          core_we_i;
   logic [bp_pkg::num_core-1:0][bp_pkg::sel_width-1:0]   core_sel_i;
   logic [bp_pkg::num_core-1:0]                          core_cyc_i;
   logic [bp_pkg::num_core-1:0]                          core_stb_i;
   bp_pkg::word_t                                        core_dat_o;
   bp_pkg::core_mask_t                                   core_ack_o;
   logic [bp_pkg::addr_width-1:0]                        mem_adr_o;
   bp_pkg::word_t                                        mem_dat_o;
   logic                                                 mem_we_o;
   logic [bp_pkg::sel_width-1:0]                         mem_sel_o;
   logic                                                 mem_cyc_o;
   logic                                                 mem_stb_o;
   bp_pkg::word_t                                        mem_dat_i;
   logic                                                 mem_ack_i;
   bp_pkg::core_mask_t                                   timer_irq_o;
   bp_pkg::core_mask_t                                   soft_irq_o;

   int seed = 30011;
   int done_cnt [bp_pkg::num_core];
   logic active [bp_pkg::num_core];

   bp_pkg::word_t      mem_words [bp_pkg::word_t];   // slave storage
   bp_pkg::word_t      model_mem [bp_pkg::word_t];   // reference
   bp_pkg::core_mask_t model_msip;
   logic [63:0]        model_cmp [bp_pkg::num_core];
   bp_pkg::word_t      seen_adr;                     // last request at the memory port
   bp_pkg::word_t      seen_dat;
   logic               seen_we;
   logic [bp_pkg::sel_width-1:0] seen_sel;

   bp_top dut_i (.*);

   bind bp_top bp_top_assert asrt_i (.*);

   initial begin
      clk_i = 1'b0;
      forever begin
         #10 clk_i = ~clk_i;
      end
   end

   function automatic bp_pkg::word_t rnd();
      return $random(seed);
   endfunction

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_word(input string name, input bp_pkg::word_t got,
                             input bp_pkg::word_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_irq(input string name, input bp_pkg::core_mask_t got,
                            input bp_pkg::core_mask_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   // ********************************************************************
   // memory slave, 0 to 3 wait cycles
   // ********************************************************************
   initial begin : mem_slave
      int   delay;
      logic busy;
      mem_ack_i = 1'b0;
      mem_dat_i = '0;
      busy = 1'b0;
      delay = 0;
      forever begin
         @(posedge clk_i);
         if (mem_ack_i) begin
            mem_ack_i <= 1'b0;
         end else if (mem_cyc_o && mem_stb_o) begin
            if (!busy) begin
               busy = 1'b1;
               delay = int'(rnd() % 4);
            end
            if (delay == 0) begin
               busy = 1'b0;
               seen_adr = mem_adr_o;
               seen_dat = mem_dat_o;
               seen_we  = mem_we_o;
               seen_sel = mem_sel_o;
               if (mem_we_o) begin
                  mem_words[mem_adr_o] = mem_dat_o;
               end
               mem_dat_i <= mem_words.exists(mem_adr_o) ? mem_words[mem_adr_o] : mem_adr_o;
               mem_ack_i <= 1'b1;
            end else begin
               delay--;
            end
         end
      end
   end

   // model update and response checks, called on the ack edge
   task automatic complete(input int c, input bp_pkg::word_t adr, input logic we,
                           input bp_pkg::word_t dat, input bp_pkg::word_t rdat);
      bp_pkg::clint_addr_u a;
      int                  k;
      bp_pkg::word_t       exp;
      a = adr;
      done_cnt[c]++;
      if (a.clint.region != bp_pkg::clint_region) begin
         check_word("mem_adr_o", seen_adr, adr);
         check_word("mem_we_o", bp_pkg::word_t'(seen_we), bp_pkg::word_t'(we));
         check_word("mem_sel_o", bp_pkg::word_t'(seen_sel),
                    bp_pkg::word_t'({bp_pkg::sel_width{1'b1}}));
         if (we) begin
            check_word("mem_dat_o", seen_dat, dat);
            model_mem[adr] = dat;
         end else begin
            exp = model_mem.exists(adr) ? model_mem[adr] : adr;
            check_word("core_dat_o", rdat, exp);
         end
      end else if (a.clint.page == bp_pkg::clint_page_msip) begin
         k = int'(a.clint.offset[11:2]);
         if (we) begin
            model_msip[k] = dat[0];
         end else begin
            check_word("core_dat_o msip", rdat, bp_pkg::word_t'(model_msip[k]));
         end
      end else if (a.clint.page == bp_pkg::clint_page_mtimecmp) begin
         k = int'(a.clint.offset[11:3]);
         if (we && a.clint.offset[2]) begin
            model_cmp[k][63:32] = dat;
         end else if (we) begin
            model_cmp[k][31:0] = dat;
         end else begin
            exp = a.clint.offset[2] ? model_cmp[k][63:32] : model_cmp[k][31:0];
            check_word("core_dat_o mtimecmp", rdat, exp);
         end
      end
      if (active[0] && active[1] && (done_cnt[0] > done_cnt[1] + 1 ||
                                     done_cnt[1] > done_cnt[0] + 1)) begin
         stop_with_failure("round-robin fairness broken, one core finished two more transfers");
      end
   endtask

   // one transfer, entered and left on a rising edge
   task automatic xfer(input int c, input bp_pkg::word_t adr, input logic we,
                       input bp_pkg::word_t dat, output bp_pkg::word_t rdat, output int cnt);
      core_adr_i[c] <= adr;
      core_dat_i[c] <= dat;
      core_we_i[c]  <= we;
      core_sel_i[c] <= '1;
      core_cyc_i[c] <= 1'b1;
      core_stb_i[c] <= 1'b1;
      cnt = 0;
      do begin
         @(posedge clk_i);
         cnt++;
         if (cnt > timeout_cycles) begin
            stop_with_failure($sformatf("timeout waiting for core_ack_o of core %0d", c));
         end
         if (core_ack_o[c] && core_ack_o != (bp_pkg::core_mask_t'(1) << c)) begin
            stop_with_failure("ack reached a core that did not issue the transfer");
         end
      end while (!core_ack_o[c]);
      rdat = core_dat_o;
      core_cyc_i[c] <= 1'b0;
      core_stb_i[c] <= 1'b0;
      complete(c, adr, we, dat, rdat);
      @(posedge clk_i);
      check_irq("soft_irq_o", soft_irq_o, model_msip);
   endtask

   // the other core wins alone, then both request on the same edge
   task automatic check_rotation(input int first);
      bp_pkg::word_t rd0;
      bp_pkg::word_t rd1;
      int            n0;
      int            n1;
      xfer(1 - first, 32'h8000_0100, 1'b0, '0, rd0, n0);
      fork
         xfer(0, 32'h8000_0104, 1'b0, '0, rd0, n0);
         xfer(1, 32'h8000_0108, 1'b0, '0, rd1, n1);
      join
      if ((first == 0) != (n0 < n1)) begin
         stop_with_failure($sformatf("arbiter did not grant core %0d first after core %0d won",
                                     first, 1 - first));
      end
   endtask

   task automatic run_core(input int c);
      bp_pkg::word_t r;
      bp_pkg::word_t adr;
      bp_pkg::word_t rdat;
      int            cnt;
      for (int n = 0; n < xfers_per_core; n++) begin
         r = rnd();
         if (r[1:0] != 2'b00) begin
            adr = 32'h8000_0000 | ((r & 32'h3F) << 2);
         end else if (r[4:3] == 2'b00) begin
            adr = 32'h0200_0000 + 32'(r[2]) * 4;      // msip
         end else begin
            adr = 32'h0200_4000 + 32'(r[2]) * 8 + 32'(r[5]) * 4;
         end
         xfer(c, adr, r[8], rnd(), rdat, cnt);
      end
      active[c] = 1'b0;
   endtask

   initial begin : main
      bp_pkg::word_t rdat;
      bp_pkg::word_t v;
      bp_pkg::word_t t1;
      int            cnt_w;
      int            cnt_r;
      int            cnt_x;
      int            wait_cnt;
      bp_pkg::core_mask_t exp_timer;
      rst_n_i = 1'b0;
      core_adr_i = '0;
      core_dat_i = '0;
      core_we_i = '0;
      core_sel_i = '0;
      core_cyc_i = '0;
      core_stb_i = '0;
      model_msip = '0;
      for (int i = 0; i < bp_pkg::num_core; i++) begin
         model_cmp[i] = '1;
         done_cnt[i] = 0;
         active[i] = 1'b1;
      end
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);

      fork
         run_core(0);
         run_core(1);
      join

      // priority rotates away from the last winner
      check_rotation(1);
      check_rotation(0);

      // msip set and read back
      xfer(0, 32'h0200_0004, 1'b1, 32'hA5A5_A5A5, rdat, cnt_x);
      xfer(0, 32'h0200_0004, 1'b0, '0, rdat, cnt_x);

      // ********************************************************************
      // mtimecmp and timer interrupt
      // ********************************************************************
      for (int i = 0; i < bp_pkg::num_core; i++) begin
         xfer(0, 32'h0200_4000 + 32'(i) * 8 + 4, 1'b1, '1, rdat, cnt_x);
         xfer(0, 32'h0200_4000 + 32'(i) * 8, 1'b1, '1, rdat, cnt_x);
      end
      @(posedge clk_i);
      check_irq("timer_irq_o", timer_irq_o, '0);
      exp_timer = '0;
      for (int i = 0; i < bp_pkg::num_core; i++) begin
         xfer(0, 32'h0200_4000 + 32'(i) * 8 + 4, 1'b1, '0, rdat, cnt_x);
         xfer(0, 32'h0200_4000 + 32'(i) * 8, 1'b1, '0, rdat, cnt_x);
         exp_timer[i] = 1'b1;
         wait_cnt = 0;
         while (!timer_irq_o[i]) begin
            @(posedge clk_i);
            wait_cnt++;
            if (wait_cnt > 1) begin   // xfer already spent one cycle after ack
               stop_with_failure($sformatf("timer_irq_o[%0d] not raised within two cycles", i));
            end
         end
         check_irq("timer_irq_o", timer_irq_o, exp_timer);
         xfer(0, 32'h0200_4000 + 32'(i) * 8, 1'b0, '0, rdat, cnt_x);
         xfer(0, 32'h0200_4000 + 32'(i) * 8 + 4, 1'b0, '0, rdat, cnt_x);
      end

      // mtime write and monotonic reads
      v = rnd() & 32'h0FFF_FFFF;
      xfer(0, 32'h0200_BFFC, 1'b1, '0, rdat, cnt_x);
      xfer(0, 32'h0200_BFF8, 1'b1, v, rdat, cnt_w);
      xfer(0, 32'h0200_BFF8, 1'b0, '0, rdat, cnt_r);
      if (rdat < v || rdat >= v + bp_pkg::word_t'(cnt_w + 1 + cnt_r)) begin
         stop_with_failure($sformatf("[ERROR] %0t mtime low got %h expected %h plus under %0d",
                                     $time, rdat, v, cnt_w + 1 + cnt_r));
      end
      t1 = rdat;
      xfer(0, 32'h0200_BFF8, 1'b0, '0, rdat, cnt_r);
      if (rdat < t1) begin
         stop_with_failure($sformatf("[ERROR] %0t mtime low got %h expected at least %h",
                                     $time, rdat, t1));
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule : bp_top_tb

//--- verification/bp_top_assert.sv
// bus protocol and reset state assertions bound into bp_top
module bp_top_assert
  (input                                 clk_i
   , input                               rst_n_i
   , input [bp_pkg::num_core-1:0]        core_cyc_i
   , input [bp_pkg::num_core-1:0]        core_stb_i
   , input bp_pkg::core_mask_t           core_ack_o
   , input                               arb_cyc
   , input                               arb_stb
   , input                               arb_ack
   , input                               mem_cyc_o
   , input                               mem_stb_o
   , input                               mem_ack_i
   , input bp_pkg::core_mask_t           timer_irq_o
   , input bp_pkg::core_mask_t           soft_irq_o
   );

   // ********************************************************************
   // reset state
   // ********************************************************************
   reset_quiet : assert property (@(posedge clk_i)
      !rst_n_i |-> (core_ack_o == '0) && !arb_ack && !mem_cyc_o && !mem_stb_o
                   && (timer_irq_o == '0) && (soft_irq_o == '0))
      else $error("outputs active in reset");

   // no ack without a live request
   arb_ack_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      arb_ack |-> arb_cyc && arb_stb) else $error("arb ack without request");
   mem_ack_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_ack_i |-> mem_cyc_o && mem_stb_o) else $error("mem ack without request");
   core_ack_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (core_ack_o & ~(core_cyc_i & core_stb_i)) == '0) else $error("core ack without request");

   // stb held until ack
   arb_stb_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      arb_stb && !arb_ack |=> arb_stb) else $error("arb stb dropped early");
   mem_stb_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_stb_o && !mem_ack_i |=> mem_stb_o) else $error("mem stb dropped early");

endmodule : bp_top_assert

//--- rtl/bp_top.sv
// top level with the core arbiter, the CLINT and the memory port
module bp_top
  (input                                                         clk_i
   , input                                                       rst_n_i

   // per-core Wishbone masters
   , input  [bp_pkg::num_core-1:0][bp_pkg::addr_width-1:0]       core_adr_i
   , input  bp_pkg::word_t [bp_pkg::num_core-1:0]                core_dat_i
   , input  [bp_pkg::num_core-1:0]                               core_we_i
   , input  [bp_pkg::num_core-1:0][bp_pkg::sel_width-1:0]        core_sel_i
   , input  [bp_pkg::num_core-1:0]                               core_cyc_i
   , input  [bp_pkg::num_core-1:0]                               core_stb_i
   , output bp_pkg::word_t                                       core_dat_o
   , output bp_pkg::core_mask_t                                  core_ack_o

   // external memory
   , output logic [bp_pkg::addr_width-1:0]                       mem_adr_o
   , output bp_pkg::word_t                                       mem_dat_o
   , output logic                                                mem_we_o
   , output logic [bp_pkg::sel_width-1:0]                        mem_sel_o
   , output logic                                                mem_cyc_o
   , output logic                                                mem_stb_o
   , input  bp_pkg::word_t                                       mem_dat_i
   , input                                                       mem_ack_i

   , output bp_pkg::core_mask_t                                  timer_irq_o
   , output bp_pkg::core_mask_t                                  soft_irq_o
   );

   logic [bp_pkg::addr_width-1:0] arb_adr;
   bp_pkg::word_t                 arb_dat_w;
   bp_pkg::word_t                 arb_dat_r;
   logic                          arb_we;
   logic [bp_pkg::sel_width-1:0]  arb_sel;
   logic                          arb_cyc;
   logic                          arb_stb;
   logic                          arb_ack;

   bp_mem_arbiter
    arb
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.core_adr_i(core_adr_i)
      ,.core_dat_i(core_dat_i)
      ,.core_we_i(core_we_i)
      ,.core_sel_i(core_sel_i)
      ,.core_cyc_i(core_cyc_i)
      ,.core_stb_i(core_stb_i)
      ,.core_dat_o(core_dat_o)
      ,.core_ack_o(core_ack_o)
      ,.bus_adr_o(arb_adr)
      ,.bus_dat_o(arb_dat_w)
      ,.bus_we_o(arb_we)
      ,.bus_sel_o(arb_sel)
      ,.bus_cyc_o(arb_cyc)
      ,.bus_stb_o(arb_stb)
      ,.bus_dat_i(arb_dat_r)
      ,.bus_ack_i(arb_ack)
      );

   bp_clint
    clint
     (.clk_i(clk_i)                    // also the real-time clock
      ,.rst_n_i(rst_n_i)
      ,.bus_adr_i(arb_adr)
      ,.bus_dat_i(arb_dat_w)
      ,.bus_we_i(arb_we)
      ,.bus_sel_i(arb_sel)
      ,.bus_cyc_i(arb_cyc)
      ,.bus_stb_i(arb_stb)
      ,.bus_dat_o(arb_dat_r)
      ,.bus_ack_o(arb_ack)
      ,.mem_adr_o(mem_adr_o)
      ,.mem_dat_o(mem_dat_o)
      ,.mem_we_o(mem_we_o)
      ,.mem_sel_o(mem_sel_o)
      ,.mem_cyc_o(mem_cyc_o)
      ,.mem_stb_o(mem_stb_o)
      ,.mem_dat_i(mem_dat_i)
      ,.mem_ack_i(mem_ack_i)
      ,.timer_irq_o(timer_irq_o)
      ,.soft_irq_o(soft_irq_o)
      );

endmodule : bp_top

//--- clint/bp_clint.sv
// CLINT decode, register strobe, memory pass-through and response mux
module bp_clint
  (input                                    clk_i
   , input                                  rst_n_i

   // core side
   , input  [bp_pkg::addr_width-1:0]        bus_adr_i
   , input  bp_pkg::word_t                  bus_dat_i
   , input                                  bus_we_i
   , input  [bp_pkg::sel_width-1:0]         bus_sel_i
   , input                                  bus_cyc_i
   , input                                  bus_stb_i
   , output bp_pkg::word_t                  bus_dat_o
   , output logic                           bus_ack_o

   // memory side
   , output logic [bp_pkg::addr_width-1:0]  mem_adr_o
   , output bp_pkg::word_t                  mem_dat_o
   , output logic                           mem_we_o
   , output logic [bp_pkg::sel_width-1:0]   mem_sel_o
   , output logic                           mem_cyc_o
   , output logic                           mem_stb_o
   , input  bp_pkg::word_t                  mem_dat_i
   , input                                  mem_ack_i

   , output bp_pkg::core_mask_t             timer_irq_o
   , output bp_pkg::core_mask_t             soft_irq_o
   );

   bp_pkg::clint_addr_u adr;
   logic                in_clint;
   logic                reg_stb;
   bp_pkg::word_t       reg_dat;
   logic                reg_ack;

   assign adr      = bus_adr_i;
   assign in_clint = (adr.clint.region == bp_pkg::clint_region);
   assign reg_stb  = bus_cyc_i & bus_stb_i & in_clint;

   // everything outside the region goes to memory unchanged
   assign mem_adr_o = adr.raw;
   assign mem_dat_o = bus_dat_i;
   assign mem_we_o  = bus_we_i;
   assign mem_sel_o = bus_sel_i;
   assign mem_cyc_o = bus_cyc_i & ~in_clint;
   assign mem_stb_o = bus_stb_i & ~in_clint;

   assign bus_dat_o = in_clint ? reg_dat : mem_dat_i;
   assign bus_ack_o = in_clint ? reg_ack : mem_ack_i;

   bp_clint_regs
    regs
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.reg_stb_i(reg_stb)
      ,.reg_we_i(bus_we_i)
      ,.reg_sel_i(bus_sel_i)
      ,.reg_adr_i(adr)
      ,.reg_dat_i(bus_dat_i)
      ,.reg_dat_o(reg_dat)
      ,.reg_ack_o(reg_ack)
      ,.timer_irq_o(timer_irq_o)
      ,.soft_irq_o(soft_irq_o)
      );

endmodule : bp_clint

//--- clint/bp_clint_regs.sv
// mtime, mtimecmp and msip registers with timer and software interrupts
module bp_clint_regs
  (input                              clk_i
   , input                            rst_n_i

   , input                            reg_stb_i
   , input                            reg_we_i
   , input  [bp_pkg::sel_width-1:0]   reg_sel_i
   , input  bp_pkg::clint_addr_u      reg_adr_i
   , input  bp_pkg::word_t            reg_dat_i
   , output bp_pkg::word_t            reg_dat_o
   , output logic                     reg_ack_o

   , output bp_pkg::core_mask_t       timer_irq_o
   , output bp_pkg::core_mask_t       soft_irq_o
   );

   logic [2*bp_pkg::data_width-1:0]                         mtime;
   logic [bp_pkg::num_core-1:0][2*bp_pkg::data_width-1:0]   mtimecmp;
   bp_pkg::core_mask_t                                      msip;

   logic [3:0]                        page;
   logic [11:0]                       offset;
   logic                              msip_hit;
   logic                              cmp_hit;
   logic                              cmp_hi;
   logic                              mtime_lo_hit;
   logic                              mtime_hi_hit;
   logic [bp_pkg::core_idx_width-1:0] msip_idx;
   logic [bp_pkg::core_idx_width-1:0] cmp_idx;
   logic                              wr;
   bp_pkg::word_t                     rd_data;

   // byte-lane merge of a write into a stored word
   function automatic bp_pkg::word_t merge(input bp_pkg::word_t old_w,
                                           input bp_pkg::word_t new_w,
                                           input logic [bp_pkg::sel_width-1:0] sel);
      bp_pkg::word_t res;
      res = old_w;
      for (int b = 0; b < bp_pkg::sel_width; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // ********************************************************************
   // offset decode
   // ********************************************************************
   assign page   = reg_adr_i.clint.page;
   assign offset = reg_adr_i.clint.offset;

   assign msip_hit = (page == bp_pkg::clint_page_msip) && (offset[11:2] < bp_pkg::num_core);
   assign msip_idx = offset[2 +: bp_pkg::core_idx_width];

   assign cmp_hit = (page == bp_pkg::clint_page_mtimecmp) && (offset[11:3] < bp_pkg::num_core);
   assign cmp_idx = offset[3 +: bp_pkg::core_idx_width];
   assign cmp_hi  = offset[2];   // high word

   assign mtime_lo_hit = (page == bp_pkg::clint_page_mtime) && (offset == bp_pkg::clint_mtime_lo);
   assign mtime_hi_hit = (page == bp_pkg::clint_page_mtime) && (offset == bp_pkg::clint_mtime_hi);

   assign wr = reg_stb_i & reg_we_i & ~reg_ack_o;   // once per transfer

   // holes read zero
   always_comb begin
      rd_data = '0;
      if (msip_hit) begin
         rd_data[0] = msip[msip_idx];
      end else if (cmp_hit) begin
         rd_data = cmp_hi ? mtimecmp[cmp_idx][63:32] : mtimecmp[cmp_idx][31:0];
      end else if (mtime_lo_hit) begin
         rd_data = mtime[31:0];
      end else if (mtime_hi_hit) begin
         rd_data = mtime[63:32];
      end
   end

   // ********************************************************************
   // registers
   // ********************************************************************
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_ack_o <= 1'b0;
         mtime     <= '0;
         mtimecmp  <= '1;
         msip      <= '0;
      end else begin
         reg_ack_o <= reg_stb_i & ~reg_ack_o;
         mtime     <= mtime + 64'd1;   // rtc is clk_i
         if (wr && mtime_lo_hit) begin
            mtime[31:0] <= merge(mtime[31:0], reg_dat_i, reg_sel_i);
         end
         if (wr && mtime_hi_hit) begin
            mtime[63:32] <= merge(mtime[63:32], reg_dat_i, reg_sel_i);
         end
         if (wr && cmp_hit && cmp_hi) begin
            mtimecmp[cmp_idx][63:32] <= merge(mtimecmp[cmp_idx][63:32], reg_dat_i, reg_sel_i);
         end
         if (wr && cmp_hit && !cmp_hi) begin
            mtimecmp[cmp_idx][31:0] <= merge(mtimecmp[cmp_idx][31:0], reg_dat_i, reg_sel_i);
         end
         if (wr && msip_hit && reg_sel_i[0]) begin
            msip[msip_idx] <= reg_dat_i[0];   // only bit 0 kept
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_stb_i) begin
         reg_dat_o <= rd_data;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         timer_irq_o <= '0;
         soft_irq_o  <= '0;
      end else begin
         for (int i = 0; i < bp_pkg::num_core; i++) begin
            timer_irq_o[i] <= (mtime >= mtimecmp[i]);
         end
         soft_irq_o <= msip;
      end
   end

endmodule : bp_clint_regs

//--- rtl/bp_mem_arbiter.sv
// round-robin Wishbone classic arbiter, per-core masters onto one bus
module bp_mem_arbiter
  (input                                                         clk_i
   , input                                                       rst_n_i

   , input  [bp_pkg::num_core-1:0][bp_pkg::addr_width-1:0]       core_adr_i
   , input  bp_pkg::word_t [bp_pkg::num_core-1:0]                core_dat_i
   , input  [bp_pkg::num_core-1:0]                               core_we_i
   , input  [bp_pkg::num_core-1:0][bp_pkg::sel_width-1:0]        core_sel_i
   , input  [bp_pkg::num_core-1:0]                               core_cyc_i
   , input  [bp_pkg::num_core-1:0]                               core_stb_i
   , output bp_pkg::word_t                                       core_dat_o
   , output bp_pkg::core_mask_t                                  core_ack_o

   , output logic [bp_pkg::addr_width-1:0]                       bus_adr_o
   , output bp_pkg::word_t                                       bus_dat_o
   , output logic                                                bus_we_o
   , output logic [bp_pkg::sel_width-1:0]                        bus_sel_o
   , output logic                                                bus_cyc_o
   , output logic                                                bus_stb_o
   , input  bp_pkg::word_t                                       bus_dat_i
   , input                                                       bus_ack_i
   );

   bp_pkg::core_mask_t                grant_q;   // one-hot, zero when idle
   bp_pkg::core_mask_t                grant_d;
   bp_pkg::core_mask_t                req;
   logic [bp_pkg::core_idx_width-1:0] last_q;    // last winner
   logic [bp_pkg::core_idx_width-1:0] cur_idx;
   logic                              idle;

   assign req  = core_cyc_i & core_stb_i;
   assign idle = (grant_q == '0);

   // first requester after the last winner
   always_comb begin : pick
      int unsigned cand;
      grant_d = '0;
      for (int k = 1; k <= bp_pkg::num_core; k++) begin
         cand = (int'(last_q) + k) % bp_pkg::num_core;
         if (req[cand] && (grant_d == '0)) begin
            grant_d[cand] = 1'b1;
         end
      end
   end

   // one-hot grant to index
   always_comb begin
      cur_idx = '0;
      for (int i = 0; i < bp_pkg::num_core; i++) begin
         if (grant_q[i]) begin
            cur_idx = i[bp_pkg::core_idx_width-1:0];
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         grant_q <= '0;
         last_q  <= '1;                 // so core 0 wins first
      end else if (idle) begin
         grant_q <= grant_d;
      end else if (bus_ack_i) begin
         grant_q <= '0;                 // idle for one cycle
         last_q  <= cur_idx;
      end
   end

   // ********************************************************************
   // bus mux and ack steering
   // ********************************************************************
   assign bus_adr_o = core_adr_i[cur_idx];
   assign bus_dat_o = core_dat_i[cur_idx];
   assign bus_we_o  = core_we_i[cur_idx];
   assign bus_sel_o = core_sel_i[cur_idx];
   assign bus_cyc_o = |(grant_q & core_cyc_i);
   assign bus_stb_o = |(grant_q & core_stb_i);

   assign core_ack_o = grant_q & {bp_pkg::num_core{bus_ack_i}};
   assign core_dat_o = bus_dat_i;   // shared by all cores

endmodule : bp_mem_arbiter

//--- common/bp_pkg.sv
// bus widths, core count, CLINT address map and the CLINT address union
package bp_pkg;

   localparam int num_core       = 2;
   localparam int core_idx_width = (num_core > 1) ? $clog2(num_core) : 1;
   localparam int addr_width     = 32;
   localparam int data_width     = 32;
   localparam int sel_width      = data_width / 8;

   typedef logic [data_width-1:0] word_t;
   typedef logic [num_core-1:0]   core_mask_t;   // irq vectors, grant

   // ********************************************************************
   // CLINT address map
   // ********************************************************************
   localparam logic [7:0] clint_region = 8'h02;   // adr[31:24]

   localparam logic [3:0] clint_page_msip     = 4'h0;
   localparam logic [3:0] clint_page_mtimecmp = 4'h4;
   localparam logic [3:0] clint_page_mtime    = 4'hB;

   localparam logic [11:0] clint_mtime_lo = 12'hFF8;
   localparam logic [11:0] clint_mtime_hi = 12'hFFC;

   // one address word, seen as a flat memory address or as CLINT fields
   typedef union packed {
      logic [addr_width-1:0] raw;
      struct packed {
         logic [7:0]  region;
         logic [7:0]  unused;
         logic [3:0]  page;
         logic [11:0] offset;
      } clint;
   } clint_addr_u;

endpackage : bp_pkg
